// ==== Makefile ====
# Verilator build and run of the fetch front end testbench

SIM  = obj_dir/Vfetch_tb
SRCS = $(wildcard design/*.sv bench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module fetch_tb -f list.f -o Vfetch_tb

# A crash or assertion stop also counts as failure
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || echo "** FAIL **" >> sim.log
	cat sim.log
	! grep -qF "** FAIL **" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/fetch_sva.sv ====
`timescale 1ns/1ns

module fetch_sva import fetch_pkg::*; (
    input logic               clock,
    input logic               reset_n,
    input logic               mem_req,
    input logic               mem_done,
    input logic               out_valid,
    input logic               out_ready,
    input decoded_inst_t      out_inst,
    input logic [COUNT_W-1:0] count
);

    logic outstanding;  // Request sent, mem_done not yet seen

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            outstanding <= 1'b0;
        else if (mem_req)
            outstanding <= 1'b1;
        else if (mem_done)
            outstanding <= 1'b0;
    end

    one_request: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req |-> !outstanding) else $error("mem_req with a request outstanding");

    held_output: assert property (@(posedge clock) disable iff (!reset_n)
        out_valid && !out_ready |=> $stable(out_inst)) else $error("out_inst changed while held");

    count_bound: assert property (@(posedge clock) disable iff (!reset_n)
        count <= COUNT_W'(QUEUE_DEPTH)) else $error("queue count above depth");

endmodule

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

    logic              clock;
    logic              reset_n;
    logic              mem_req;
    line_req_t         mem_req_line;
    logic              mem_done;
    logic [LINE_W-1:0] mem_line;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_pc;
    logic              out_valid;
    decoded_inst_t     out_inst;
    logic              out_ready;

    integer            seed;
    logic [31:0]       mem_key;      // Drawn once to salt every memory word
    logic [ADDR_W-1:0] resp_addr;    // Line address the memory is serving
    int                resp_wait;
    logic              resp_busy;
    logic [1:0]        ready_mode;   // 0 low, 1 high, 2 random
    logic [ADDR_W-1:0] exp_pc;       // Model of the next output address
    logic [31:0]       exp_word;
    int                beat_count;
    logic              wait_first;
    logic [ADDR_W-1:0] first_addr;   // First output after the last redirect
    logic [4:0]        class_seen;
    string             test_name;
    int                errors;
    int                tests_run;
    int                failed_tests;
    logic              timed_out;
    int                mark;
    logic [ADDR_W-1:0] target;

    fetch_top i_fetch_top (.*);

    bind fetch_top fetch_sva i_fetch_sva (.*);

    always #5 clock = ~clock;

    // Memory contents hash the full address with the key
    function automatic logic [31:0] word_at(input logic [ADDR_W-1:0] addr);
        logic [31:0] x;
        x = addr[31:0] ^ {addr[47:32], 16'h0} ^ mem_key;
        x = x * 32'h9e3779b1;
        x = x ^ (x >> 16);
        x = x * 32'h85ebca6b;
        return x ^ (x >> 13);
    endfunction

    function automatic logic [LINE_W-1:0] line_at(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] line;
        for (int i = 0; i < LINE_WORDS; i++)
            line[i*INST_W +: INST_W] = word_at(base + ADDR_W'(4 * i));  // Word 0 lowest
        return line;
    endfunction

    // Class by the top nibble
    function automatic op_class_t class_of(input logic [31:0] word);
        case (word[31:28])
            4'h8, 4'h9:       return OP_LOAD;
            4'hA, 4'hB:       return OP_STORE;
            4'hC, 4'hD, 4'hE: return OP_BRANCH;
            4'hF:             return OP_SYSTEM;
            default:          return OP_ALU;
        endcase
    endfunction

    // Word-aligned address inside a random line but never word 0
    function automatic logic [ADDR_W-1:0] random_target();
        logic [63:0] rnd;
        logic [3:0]  widx;
        rnd  = {$random(seed), $random(seed)};
        widx = 4'(1 + {$random(seed)} % 15);
        return {rnd[ADDR_W-1:LINE_OFFSET_W], widx, 2'b00};
    endfunction

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        mark      = errors;
    endtask

    // Settles on the falling edge, after every compare of the rising edge
    task automatic finish_test();
        @(negedge clock);
        tests_run++;
        if (errors == mark && !timed_out) begin
            $display("test %s: ok", test_name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", test_name, errors - mark);
        end
    endtask

    task automatic wait_beats(input int n, input int limit);
        int goal;
        int cycles;
        goal   = beat_count + n;
        cycles = 0;
        while (beat_count < goal && !timed_out) begin
            @(posedge clock);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: %0d outputs did not arrive within %0d cycles in %s",
                         n, limit, test_name);
                timed_out = 1'b1;
            end
        end
    endtask

    // Returns just after the edge on which mem_req was seen
    task automatic wait_request(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: no memory request within %0d cycles in %s", limit, test_name);
                timed_out = 1'b1;
            end
        end while (!mem_req && !timed_out);
    endtask

    task automatic drive_redirect(input logic [ADDR_W-1:0] pc);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clock);
        redirect    <= 1'b0;
    endtask

    // Memory responder and out_ready driver
    always @(posedge clock) begin
        mem_done  <= 1'b0;
        out_ready <= ready_mode[1] ? 1'($random(seed)) : ready_mode[0];
        if (mem_req) begin
            resp_addr <= mem_req_line.line_addr;
            resp_wait <= 1 + {$random(seed)} % 6;  // 1 to 6 cycles
            resp_busy <= 1'b1;
        end else if (resp_busy) begin
            if (resp_wait == 1) begin
                mem_done  <= 1'b1;
                mem_line  <= line_at(resp_addr);
                resp_busy <= 1'b0;
            end else begin
                resp_wait <= resp_wait - 1;
            end
        end
    end

    // Reference model compares every accepted beat
    always @(posedge clock) begin
        if (reset_n && redirect) begin
            exp_pc = redirect_pc;  // Output in this cycle is flushed
            wait_first <= 1'b1;
        end else if (reset_n && out_valid && out_ready) begin
            exp_word = word_at(exp_pc);
            check("addr", exp_pc, out_inst.entry.addr);
            check("inst", exp_word, out_inst.entry.inst);
            check("class", class_of(exp_word), out_inst.op_class);
            if (out_inst.op_class == class_of(exp_word))
                class_seen[class_of(exp_word)] = 1'b1;
            if (wait_first)
                first_addr <= out_inst.entry.addr;
            wait_first <= 1'b0;
            exp_pc = exp_pc + 4;
            beat_count <= beat_count + 1;
        end
    end

    initial begin
        seed        = 32'h5e637474;
        clock       = 1'b0;
        reset_n     = 1'b0;
        mem_done    = 1'b0;
        mem_line    = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        out_ready   = 1'b0;
        ready_mode  = 2'd0;
        resp_busy   = 1'b0;
        resp_wait   = 0;
        exp_pc      = RESET_PC;
        beat_count  = 0;
        wait_first  = 1'b0;
        class_seen  = '0;
        errors      = 0;
        tests_run   = 0;
        failed_tests = 0;
        timed_out   = 1'b0;
        mem_key     = $random(seed);

        start_test("reset");
        repeat (2) begin
            @(posedge clock);
            check("out_valid", 0, out_valid);
            check("mem_req", 0, mem_req);
        end
        reset_n <= 1'b1;
        @(posedge clock);
        check("out_valid", 0, out_valid);  // Just after release
        check("mem_req", 0, mem_req);
        wait_request(20);
        check("first line", RESET_PC, mem_req_line.line_addr);
        finish_test();

        start_test("sequential");
        ready_mode <= 2'd1;
        wait_beats(200, 3000);
        finish_test();

        start_test("unaligned redirect");
        target = random_target();
        @(posedge clock);
        drive_redirect(target);
        wait_beats(40, 1000);
        check("first addr", target, first_addr);
        finish_test();

        start_test("back-pressure");
        ready_mode <= 2'd2;
        wait_beats(200, 5000);
        finish_test();

        start_test("stale response");
        ready_mode <= 2'd1;
        target = random_target();
        wait_request(500);
        drive_redirect(target);  // Lands before mem_done
        wait_beats(40, 1000);
        check("first addr", target, first_addr);
        finish_test();

        start_test("opcode classes");
        for (int c = 0; c < 5; c++) begin
            if (!class_seen[c]) begin
                $display("op class %0d was never seen in the random run", c);
                errors++;
            end
        end
        finish_test();

        $display("tests %0d, failed %0d, outputs checked %0d, errors %0d",
                 tests_run, failed_tests, beat_count, errors);
        if (errors == 0 && failed_tests == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== design/fetch_control.sv ====
`timescale 1ns/1ns

module fetch_control import fetch_pkg::*; (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               redirect,
    input  logic [ADDR_W-1:0]  redirect_pc,
    input  logic [COUNT_W-1:0] count,
    input  logic               line_written,
    input  logic               mem_done,
    output logic               mem_req,
    output line_req_t          mem_req_line,
    output logic [ADDR_W-1:0]  line_fetch_pc,
    output logic               line_drop
);

    typedef enum logic [1:0] {
        IDLE,        // No line in flight
        WAIT_LINE,   // Request out, waiting for mem_done
        WRITING      // Splitter is pushing the line
    } fetch_state_t;

    fetch_state_t      state;
    logic [ADDR_W-1:0] next_pc;    // Entry address of the next line to fetch
    logic [ADDR_W-1:0] line_base;  // next_pc rounded down to its line
    logic              can_fetch;

    assign line_base = {next_pc[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};

    // Refill decision, also waits out a stale response so only one is ever outstanding
    assign can_fetch = (state == IDLE) && !line_drop && !redirect &&
                       (count <= COUNT_W'(REFILL_LEVEL));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= IDLE;
            next_pc   <= RESET_PC;
            mem_req   <= 1'b0;
            line_drop <= 1'b0;
        end else begin
            mem_req <= 1'b0;  // Single-cycle strobe
            if (redirect) begin
                state   <= IDLE;
                next_pc <= redirect_pc;
                // Response still owed by memory becomes stale
                line_drop <= (line_drop || state == WAIT_LINE) && !mem_done;
            end else begin
                if (mem_done)
                    line_drop <= 1'b0;
                case (state)
                    IDLE: if (can_fetch) begin
                        mem_req <= 1'b1;
                        state   <= WAIT_LINE;
                        next_pc <= {line_base[ADDR_W-1:LINE_OFFSET_W] + 1'b1,
                                    {LINE_OFFSET_W{1'b0}}};  // Following line
                    end
                    WAIT_LINE: if (mem_done) state <= WRITING;
                    WRITING:   if (line_written) state <= IDLE;
                    default:   state <= IDLE;
                endcase
            end
        end
    end

    // Request payload, captured together with the strobe
    always_ff @(posedge clock) begin
        if (can_fetch) begin
            mem_req_line.line_addr <= line_base;
            line_fetch_pc          <= next_pc;  // Unaligned entry point for the splitter
        end
    end

endmodule

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // Address and word geometry
    localparam int ADDR_W        = 48;
    localparam int INST_W        = 32;
    localparam int LINE_WORDS    = 16;
    localparam int LINE_W        = LINE_WORDS * INST_W;  // 512 bit memory line
    localparam int WORD_IDX_W    = 4;                    // Word index within a line
    localparam int LINE_OFFSET_W = 6;                    // Byte offset within a 64-byte line

    // Queue sizing
    localparam int QUEUE_DEPTH   = 24;
    localparam int COUNT_W       = 5;   // Holds 0..24
    localparam int REFILL_LEVEL  = 8;   // 8 left plus one full line still fits

    // Fetch address after reset, line aligned
    localparam logic [ADDR_W-1:0] RESET_PC = 48'h0000_0000_1000;

    // Opcode class from instruction bits 31:28
    typedef enum logic [2:0] {
        OP_ALU,      // 0..7
        OP_LOAD,     // 8..9
        OP_STORE,    // 10..11
        OP_BRANCH,   // 12..14
        OP_SYSTEM    // 15
    } op_class_t;

    // Queue entry, instruction word above its address
    typedef struct packed {
        logic [INST_W-1:0] inst;
        logic [ADDR_W-1:0] addr;
    } tagged_inst_t;

    // Downstream output
    typedef struct packed {
        tagged_inst_t entry;
        op_class_t    op_class;
    } decoded_inst_t;

    // Line request to instruction memory
    typedef struct packed {
        logic [ADDR_W-1:0] line_addr;  // Low six bits always zero
    } line_req_t;

endpackage

// ==== design/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    // Instruction memory
    output logic              mem_req,
    output line_req_t         mem_req_line,
    input  logic              mem_done,
    input  logic [LINE_W-1:0] mem_line,
    // Redirect from the back end
    input  logic              redirect,
    input  logic [ADDR_W-1:0] redirect_pc,
    // Downstream
    output logic              out_valid,
    output decoded_inst_t     out_inst,
    input  logic              out_ready
);

    logic [ADDR_W-1:0]  line_fetch_pc;
    logic               line_drop;
    logic               line_written;
    logic               push;
    tagged_inst_t       push_entry;
    logic               pop;
    tagged_inst_t       head;
    logic               empty;
    logic               full;
    logic [COUNT_W-1:0] count;

    fetch_control i_fetch_control (
        .clock, .reset_n, .redirect, .redirect_pc, .count, .line_written,
        .mem_done, .mem_req, .mem_req_line, .line_fetch_pc, .line_drop
    );

    line_splitter i_line_splitter (
        .clock, .reset_n, .redirect, .mem_done, .mem_line, .line_fetch_pc,
        .line_drop, .full, .push, .push_entry, .line_written
    );

    inst_queue i_inst_queue (
        .clock, .reset_n, .flush(redirect), .push, .push_entry, .pop,
        .head, .empty, .full, .count
    );

    inst_predecode i_inst_predecode (
        .clock, .reset_n, .redirect, .head, .empty, .pop,
        .out_ready, .out_valid, .out_inst
    );

endmodule

// ==== design/inst_predecode.sv ====
`timescale 1ns/1ns

module inst_predecode import fetch_pkg::*; (
    input  logic          clock,
    input  logic          reset_n,
    input  logic          redirect,
    input  tagged_inst_t  head,
    input  logic          empty,
    output logic          pop,
    input  logic          out_ready,
    output logic          out_valid,
    output decoded_inst_t out_inst
);

    // Class from the top four instruction bits
    function automatic op_class_t classify(input logic [3:0] top);
        if (top <= 4'd7)
            return OP_ALU;
        else if (top <= 4'd9)
            return OP_LOAD;
        else if (top <= 4'd11)
            return OP_STORE;
        else if (top <= 4'd14)
            return OP_BRANCH;
        else
            return OP_SYSTEM;
    endfunction

    // Refill the output register when it is empty or being consumed
    assign pop = !empty && (!out_valid || out_ready);

    always_ff @(posedge clock) begin
        if (pop) begin
            out_inst.entry    <= head;
            out_inst.op_class <= classify(head.inst[INST_W-1 -: 4]);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (redirect) begin
            out_valid <= 1'b0;  // Wrong-path instruction
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // Consumed, nothing behind it
        end
    end

endmodule

// ==== design/inst_queue.sv ====
`timescale 1ns/1ns

module inst_queue import fetch_pkg::*; (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               flush,
    input  logic               push,
    input  tagged_inst_t       push_entry,
    input  logic               pop,
    output tagged_inst_t       head,
    output logic               empty,
    output logic               full,
    output logic [COUNT_W-1:0] count
);

    tagged_inst_t       entries [QUEUE_DEPTH];
    logic [COUNT_W-1:0] rd_ptr;
    logic [COUNT_W-1:0] wr_ptr;
    logic               do_push;
    logic               do_pop;

    // Pointer step with wrap at the last entry
    function automatic logic [COUNT_W-1:0] ptr_next(input logic [COUNT_W-1:0] ptr);
        return (ptr == COUNT_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == COUNT_W'(QUEUE_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = entries[rd_ptr];  // First word falls through

    always_ff @(posedge clock) begin
        if (do_push)
            entries[wr_ptr] <= push_entry;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;  // Drops everything, including a push this cycle
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

// ==== design/line_splitter.sv ====
`timescale 1ns/1ns

module line_splitter import fetch_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              redirect,
    input  logic              mem_done,
    input  logic [LINE_W-1:0] mem_line,
    input  logic [ADDR_W-1:0] line_fetch_pc,
    input  logic              line_drop,
    input  logic              full,
    output logic              push,
    output tagged_inst_t      push_entry,
    output logic              line_written
);

    logic [INST_W-1:0]     line_buf [LINE_WORDS];  // Latched line with word 0 at bits 31:0
    logic [ADDR_W-1:0]     base_addr;              // Address of word 0
    logic [WORD_IDX_W-1:0] word_idx;               // Next word to push
    logic                  writing;
    logic                  take_line;
    logic [WORD_IDX_W-1:0] start_word;

    // Stale lines and lines racing a redirect are dropped
    assign take_line  = mem_done && !line_drop && !redirect;
    assign start_word = line_fetch_pc[LINE_OFFSET_W-1:2];  // Words before it are skipped

    // One word per cycle while the queue has room
    assign push                = writing && !full;
    assign push_entry.inst     = line_buf[word_idx];
    assign push_entry.addr     = base_addr + ADDR_W'({word_idx, 2'b00});
    assign line_written        = push && (word_idx == WORD_IDX_W'(LINE_WORDS - 1));

    // Line capture
    always_ff @(posedge clock) begin
        if (take_line) begin
            for (int i = 0; i < LINE_WORDS; i++)
                line_buf[i] <= mem_line[i*INST_W +: INST_W];
            base_addr <= {line_fetch_pc[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            writing  <= 1'b0;
            word_idx <= '0;
        end else if (redirect) begin
            writing  <= 1'b0;  // Flush along with the queue
            word_idx <= '0;
        end else if (take_line) begin
            writing  <= 1'b1;
            word_idx <= start_word;
        end else if (push) begin
            word_idx <= word_idx + 1'b1;
            if (line_written)
                writing <= 1'b0;  // Word 15 went out
        end
    end

endmodule

// ==== list.f ====
design/fetch_pkg.sv
design/fetch_control.sv
design/line_splitter.sv
design/inst_queue.sv
design/inst_predecode.sv
design/fetch_top.sv
bench/fetch_sva.sv
bench/fetch_tb.sv
